/* list.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_addr_queue.sv
verilog/fetch_next_stage.sv
verilog/fetch_top.sv
testbench/fetch_tb_mem.sv
testbench/fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= fetch_tb
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* testbench/fetch_tb.sv */
`include "fetch_defines.svh"

module fetch_tb;

	localparam int RESET_CYCLES = 16;
	localparam int RUN_WORDS = 40;	// Per free, decode-stall and memory-stall run
	localparam int TAIL_WORDS = 30;	// After the jump and after the PSR change
	localparam int TOTAL_WORDS = 3 * RUN_WORDS + 2 * TAIL_WORDS + 24;	// Slack for waits
	localparam logic [31:0] JUMP_TARGET = 32'h0000_1000;

	logic iCLOCK = 1'b0;
	logic reset = 1'b1;
	logic set_pc_valid = 1'b0;
	logic [31:0] set_pc = '0;
	logic hold = 1'b0;
	logic [31:0] sysreg_psr = '0;	// Kernel mode
	logic next_lock = 1'b0;
	logic stall = 1'b0;
	logic fetch_lock;
	logic mem_valid;
	logic [31:0] mem_inst;
	logic mem_epoch;
	logic mem_lock;
	fetch_pkg::fetch_req_t fetch_req;
	logic fetch_req_valid;
	fetch_pkg::next_inst_t next;
	logic next_valid;
	logic lock_random = 1'b0;
	logic stall_random = 1'b0;
	logic exp_kernel = 1'b1;
	logic [31:0] exp_addr = `FETCH_RESET_VECTOR;
	logic [31:0] last_pc = '0;	// pc field of the last word decode took
	logic [31:0] lfsr_state = 32'h34a;
	int delivered = 0;
	int checks = 0;
	int errors = 0;

	fetch_top u_dut(.iCLOCK(iCLOCK), .reset(reset), .set_pc_valid(set_pc_valid),
		.set_pc(set_pc), .hold(hold), .sysreg_psr(sysreg_psr), .fetch_lock(fetch_lock),
		.mem_valid(mem_valid), .mem_inst(mem_inst), .mem_epoch(mem_epoch),
		.next_lock(next_lock), .fetch_req(fetch_req), .fetch_req_valid(fetch_req_valid),
		.mem_lock(mem_lock), .next(next), .next_valid(next_valid));

	fetch_tb_mem #(.LATENCY(2)) u_mem(.iCLOCK(iCLOCK), .stall(stall), .fetch_req(fetch_req),
		.fetch_req_valid(fetch_req_valid), .mem_lock(mem_lock), .fetch_lock(fetch_lock),
		.mem_valid(mem_valid), .mem_inst(mem_inst), .mem_epoch(mem_epoch));

	always #5 iCLOCK = !iCLOCK;

	// Expected decode word for a fetch address
	function automatic fetch_pkg::next_inst_t expected_next(input logic [31:0] addr,
		input logic kernel);
		fetch_pkg::inst_word_u w;
		fetch_pkg::next_inst_t e;
		w.raw = {2'b11, addr[31:2]};
		if (addr[5:2] == 4'hf) begin	// Sixteenth word, forward branch
			w.br.spare = 1'b0;
			w.br.opcode = `OC_B;
			w.br.disp = {19'd0, addr[7:6]} + 21'd2;
		end
		e.inst = w.raw;
		e.pc = addr + 32'd4;
		e.kernel = kernel;
		e.predict = w.br.opcode == `OC_B && !w.br.disp[20] && w.br.disp != '0;
		return e;
	endfunction

	// Taken branch goes to its target, all else falls through
	function automatic logic [31:0] follow_pc(input fetch_pkg::next_inst_t e);
		fetch_pkg::inst_word_u w;
		w.raw = e.inst;
		if (e.predict) begin
			return e.pc - 32'd4 + 32'(w.br.disp) * 32'd4;	// Fetch address plus disp words
		end
		return e.pc;
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// Taps 32 22 2 1
	endfunction

	task automatic random_bit(output logic b);
		lfsr_state = lfsr_step(lfsr_state);
		b = lfsr_state[0];
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic wait_words(input int count);
		int target;
		target = delivered + count;
		while (delivered < target) begin
			@(negedge iCLOCK);
		end
	endtask

	// Compare each word as decode takes it
	always @(posedge iCLOCK) begin
		fetch_pkg::next_inst_t want;
		if (!reset) begin
			if (next_lock) begin
				check_value("mem_lock under next_lock", 32'(mem_lock), 32'd1);
			end
			if (next_valid && !next_lock) begin
				want = expected_next(exp_addr, exp_kernel);
				check_value("next.inst", next.inst, want.inst);
				check_value("next.pc", next.pc, want.pc);
				check_value("next.kernel", 32'(next.kernel), 32'(want.kernel));
				check_value("next.predict", 32'(next.predict), 32'(want.predict));
				last_pc = next.pc;
				delivered++;
				exp_addr = follow_pc(want);
			end
			if (set_pc_valid) begin
				exp_addr = set_pc;	// Everything older is gone
			end
		end
	end

	// Random locks, about one cycle in four
	always @(negedge iCLOCK) begin
		logic b0;
		logic b1;
		if (lock_random) begin
			random_bit(b0);
			random_bit(b1);
			next_lock <= b0 & b1;
		end else begin
			next_lock <= 1'b0;
		end
		if (stall_random) begin
			random_bit(b0);
			random_bit(b1);
			stall <= b0 & b1;
		end else begin
			stall <= 1'b0;
		end
	end

	initial begin
		repeat (RESET_CYCLES) @(negedge iCLOCK);
		check_value("next_valid in reset", 32'(next_valid), 32'd0);
		check_value("fetch_req_valid in reset", 32'(fetch_req_valid), 32'd0);
		reset <= 1'b0;
		wait_words(RUN_WORDS);	// Free run from the reset vector
		lock_random <= 1'b1;
		wait_words(RUN_WORDS);
		lock_random <= 1'b0;
		stall_random <= 1'b1;
		wait_words(RUN_WORDS);
		stall_random <= 1'b0;
		// Jump after word 8 of a block, far from any redirect, so one epoch bit is enough
		while (last_pc[5:2] != 4'd9) @(negedge iCLOCK);
		set_pc <= JUMP_TARGET;
		set_pc_valid <= 1'b1;
		@(negedge iCLOCK);
		set_pc_valid <= 1'b0;
		wait_words(TAIL_WORDS);
		hold <= 1'b1;	// Drain before touching the PSR
		@(negedge iCLOCK);
		while (!u_dut.u_addr_queue.empty || next_valid) begin
			check_value("fetch_req_valid under hold", 32'(fetch_req_valid), 32'd0);
			@(negedge iCLOCK);
		end
		sysreg_psr <= 32'h0000_0020;	// Bit 5 set, user mode
		exp_kernel <= 1'b0;
		hold <= 1'b0;
		wait_words(TAIL_WORDS);
		$display("Done: %0d words, %0d checks, %0d errors", delivered, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + 40 * TOTAL_WORDS) @(posedge iCLOCK);
		$display("Timeout: the run stalled after %0d delivered words", delivered);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* testbench/fetch_tb_mem.sv */
`include "fetch_defines.svh"

module fetch_tb_mem #(
	parameter int LATENCY = 2	// Cycles from request to return
) (
	input wire iCLOCK,
	input wire stall,	// Random back-pressure from the testbench
	input fetch_pkg::fetch_req_t fetch_req,
	input wire fetch_req_valid,
	input wire mem_lock,
	output logic fetch_lock,
	output logic mem_valid,
	output logic [31:0] mem_inst,
	output logic mem_epoch
);

	fetch_pkg::fetch_req_t pend_req[$];	// Requests in issue order
	int pend_due[$];	// Cycle each one may come back
	int cycle = 0;
	logic taken = 1'b1;	// Return register consumed at the last edge

	// Every sixteenth word is a forward branch, the rest unique per address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		fetch_pkg::inst_word_u w;
		w.raw = {2'b11, addr[31:2]};	// Bit 30 set, never the branch opcode
		if (addr[5:2] == 4'hf) begin
			w.br.spare = 1'b0;
			w.br.opcode = `OC_B;
			w.br.disp = {19'd0, addr[7:6]} + 21'd2;	// Two to five words ahead
		end
		return w.raw;
	endfunction

	assign fetch_lock = stall;

	initial begin
		mem_valid = 1'b0;
		mem_inst = '0;
		mem_epoch = 1'b0;
	end

	always @(posedge iCLOCK) begin
		cycle = cycle + 1;
		if (fetch_req_valid) begin
			pend_req.push_back(fetch_req);
			pend_due.push_back(cycle + LATENCY);
		end
		taken = !mem_lock;	// Locked word stays put
	end

	// Return register changes on the falling edge only
	always @(negedge iCLOCK) begin
		if (taken) begin
			if (pend_req.size() > 0 && pend_due[0] <= cycle) begin
				mem_valid <= 1'b1;
				mem_inst <= word_at(pend_req[0].addr);
				mem_epoch <= pend_req[0].epoch;	// Echo of the request epoch
				void'(pend_req.pop_front());
				void'(pend_due.pop_front());
			end else begin
				mem_valid <= 1'b0;
			end
		end
	end

endmodule

/* verilog/fetch_top.sv */
module fetch_top(
	input wire iCLOCK,
	input wire reset,
	input wire set_pc_valid,
	input wire [31:0] set_pc,
	input wire hold,
	input wire [31:0] sysreg_psr,
	input wire fetch_lock,	// Memory not ready
	input wire mem_valid,
	input wire [31:0] mem_inst,
	input wire mem_epoch,
	input wire next_lock,	// Decode stall
	output fetch_pkg::fetch_req_t fetch_req,
	output logic fetch_req_valid,
	output logic mem_lock,
	output fetch_pkg::next_inst_t next,
	output logic next_valid
);

	fetch_pkg::redirect_t redirect;
	fetch_pkg::queue_entry_t entry;
	fetch_pkg::queue_entry_t head;
	logic epoch;
	logic queue_full;
	logic queue_empty;
	logic pop;
	logic queue_flush;

	// Jump or predicted branch invalidates everything in flight
	assign queue_flush = set_pc_valid || redirect.valid;

	fetch_pc_gen u_pc_gen(
		.iCLOCK(iCLOCK),
		.reset(reset),
		.set_pc_valid(set_pc_valid),
		.set_pc(set_pc),
		.hold(hold),
		.sysreg_psr(sysreg_psr),
		.redirect(redirect),
		.fetch_lock(fetch_lock),
		.queue_full(queue_full),
		.fetch_req(fetch_req),
		.fetch_req_valid(fetch_req_valid),
		.entry(entry),
		.epoch(epoch)
	);

	fetch_addr_queue u_addr_queue(
		.iCLOCK(iCLOCK),
		.reset(reset),
		.flush(queue_flush),
		.wr_en(fetch_req_valid),	// Every issued request is tracked
		.wr_data(entry),
		.rd_en(pop),
		.rd_data(head),
		.full(queue_full),
		.empty(queue_empty)
	);

	fetch_next_stage u_next_stage(
		.iCLOCK(iCLOCK),
		.reset(reset),
		.set_pc_valid(set_pc_valid),
		.mem_valid(mem_valid),
		.mem_inst(mem_inst),
		.mem_epoch(mem_epoch),
		.epoch(epoch),
		.head(head),
		.queue_empty(queue_empty),
		.next_lock(next_lock),
		.pop(pop),
		.redirect(redirect),
		.mem_lock(mem_lock),
		.next(next),
		.next_valid(next_valid)
	);

endmodule

/* verilog/fetch_next_stage.sv */
`include "fetch_defines.svh"

module fetch_next_stage(
	input wire iCLOCK,
	input wire reset,
	input wire set_pc_valid,	// Jump clears the output
	input wire mem_valid,
	input wire [31:0] mem_inst,
	input wire mem_epoch,
	input wire epoch,
	input fetch_pkg::queue_entry_t head,
	input wire queue_empty,
	input wire next_lock,
	output logic pop,
	output fetch_pkg::redirect_t redirect,
	output logic mem_lock,
	output fetch_pkg::next_inst_t next,
	output logic next_valid
);

	fetch_pkg::inst_word_u word;
	fetch_pkg::next_inst_t b_next;
	logic b_next_valid;
	logic current;	// Return belongs to the live epoch
	logic accept;
	logic is_branch;

	always_comb begin
		word.raw = mem_inst;
		current = mem_valid && (mem_epoch == epoch);
		accept = current && !next_lock;
		// Forward immediate branch, predicted taken
		is_branch = (word.br.opcode == `OC_B) && (word.br.disp > 0);
	end

	// Stale returns stay off the queue, it was flushed with their epoch
	assign pop = accept;

	assign redirect.valid = accept && is_branch && !set_pc_valid;
	assign redirect.target = head.addr +
		{{9{word.br.disp[20]}}, word.br.disp, 2'b00};	// Words to bytes

	// Memory return register freezes along with decode
	assign mem_lock = next_lock;

	always_ff @(posedge iCLOCK) begin
		if (reset) begin
			b_next_valid <= 1'b0;
		end else if (set_pc_valid) begin
			b_next_valid <= 1'b0;	// Older word is dead
		end else if (!next_lock) begin
			b_next_valid <= accept;
		end
	end

	// Payload, valid says whether it means anything
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			b_next.inst <= word.raw;
			b_next.pc <= head.addr + 32'd4;
			b_next.kernel <= head.kernel;
			b_next.predict <= is_branch;	// Branch itself still goes out
		end
	end

	assign next = b_next;
	assign next_valid = b_next_valid;

	// A live return always has its request waiting in the queue
	a_return_has_entry: assert property (@(posedge iCLOCK) disable iff (reset)
		current |-> !queue_empty);

	// Queue head and return must come from the same epoch
	a_head_epoch: assert property (@(posedge iCLOCK) disable iff (reset)
		accept |-> head.epoch == epoch);

endmodule

/* verilog/fetch_addr_queue.sv */
`include "fetch_defines.svh"

module fetch_addr_queue(
	input wire iCLOCK,
	input wire reset,
	input wire flush,
	input wire wr_en,
	input fetch_pkg::queue_entry_t wr_data,
	input wire rd_en,
	output fetch_pkg::queue_entry_t rd_data,
	output logic full,
	output logic empty
);

	fetch_pkg::queue_entry_t mem [`FETCH_QUEUE_DEPTH];
	logic [`FETCH_QUEUE_AW-1:0] b_wr_ptr;
	logic [`FETCH_QUEUE_AW-1:0] b_rd_ptr;
	logic [`FETCH_QUEUE_AW:0] b_count;	// One extra bit for full
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Storage, written only
	always_ff @(posedge iCLOCK) begin
		if (do_wr) begin
			mem[b_wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (reset || flush) begin	// Flush drops everything in one cycle
			b_wr_ptr <= '0;
			b_rd_ptr <= '0;
			b_count <= '0;
		end else begin
			if (do_wr) begin
				b_wr_ptr <= b_wr_ptr + 1'b1;	// Wraps at the depth
			end
			if (do_rd) begin
				b_rd_ptr <= b_rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: b_count <= b_count + 1'b1;
				2'b01: b_count <= b_count - 1'b1;
				default: b_count <= b_count;	// Both or neither
			endcase
		end
	end

	// Show-ahead, head visible without a read
	assign rd_data = mem[b_rd_ptr];
	assign full = b_count == (`FETCH_QUEUE_AW+1)'(`FETCH_QUEUE_DEPTH);
	assign empty = b_count == '0;

	// Producer must stop at full
	a_no_write_full: assert property (@(posedge iCLOCK) disable iff (reset)
		wr_en && !flush |-> !full);

	// Consumer pops only what was requested
	a_no_read_empty: assert property (@(posedge iCLOCK) disable iff (reset)
		rd_en && !flush |-> !empty);

endmodule

/* verilog/fetch_pc_gen.sv */
`include "fetch_defines.svh"

module fetch_pc_gen(
	input wire iCLOCK,
	input wire reset,
	input wire set_pc_valid,	// Jump
	input wire [31:0] set_pc,
	input wire hold,
	input wire [31:0] sysreg_psr,
	input fetch_pkg::redirect_t redirect,
	input wire fetch_lock,
	input wire queue_full,
	output fetch_pkg::fetch_req_t fetch_req,
	output logic fetch_req_valid,
	output fetch_pkg::queue_entry_t entry,
	output logic epoch
);

	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_READ = 1'b1;

	logic state;	// Next state
	logic b_state;
	logic [31:0] b_pc;
	logic b_epoch;

	// Jump restarts reading at once, hold parks in idle
	always_comb begin
		if (set_pc_valid) begin
			state = ST_READ;
		end else if (redirect.valid) begin
			state = b_state;	// Keep going from the target
		end else if (hold) begin
			state = ST_IDLE;
		end else begin
			state = ST_READ;	// Idle lasts one cycle
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (reset) begin
			b_state <= ST_IDLE;
		end else begin
			b_state <= state;
		end
	end

	// No issue in a cycle that moves the PC elsewhere
	assign fetch_req_valid = (b_state == ST_READ) && !hold && !set_pc_valid &&
		!redirect.valid && !fetch_lock && !queue_full;

	always_ff @(posedge iCLOCK) begin
		if (reset) begin
			b_pc <= `FETCH_RESET_VECTOR;
		end else if (set_pc_valid) begin
			b_pc <= {set_pc[31:2], 2'b00};	// Force word alignment
		end else if (redirect.valid) begin
			b_pc <= redirect.target;
		end else if (fetch_req_valid) begin	// Already low under hold
			b_pc <= b_pc + 32'd4;
		end
	end

	// New epoch on every flush, older returns become stale
	always_ff @(posedge iCLOCK) begin
		if (reset) begin
			b_epoch <= 1'b0;
		end else if (set_pc_valid || redirect.valid) begin
			b_epoch <= !b_epoch;
		end
	end

	assign fetch_req.addr = b_pc;
	assign fetch_req.epoch = b_epoch;
	assign entry.addr = b_pc;
	assign entry.kernel = !(sysreg_psr[`PSR_KERNEL_HI] || sysreg_psr[`PSR_KERNEL_LO]);
	assign entry.epoch = b_epoch;
	assign epoch = b_epoch;

	// Jump and redirect targets keep the PC on word boundaries
	a_pc_aligned: assert property (@(posedge iCLOCK) disable iff (reset)
		b_pc[1:0] == 2'b00);

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

	// Request toward instruction memory
	typedef struct packed {
		logic [31:0] addr;
		logic epoch;	// Returned with the word
	} fetch_req_t;

	// Address queue slot, one per request in flight
	typedef struct packed {
		logic [31:0] addr;
		logic kernel;
		logic epoch;
	} queue_entry_t;

	// Branch format of an instruction word
	typedef struct packed {
		logic spare;
		logic [9:0] opcode;
		logic signed [20:0] disp;	// Word displacement
	} inst_branch_t;

	// Same 32 bits, raw or as a branch
	typedef union packed {
		logic [31:0] raw;
		inst_branch_t br;
	} inst_word_u;

	// Word handed to decode
	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] pc;	// Fetch address plus 4
		logic kernel;
		logic predict;	// Static taken guess
	} next_inst_t;

	// Fetch redirect from predecode
	typedef struct packed {
		logic valid;
		logic [31:0] target;
	} redirect_t;

endpackage

/* verilog/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// In-flight fetch queue
`define FETCH_QUEUE_DEPTH 8
`define FETCH_QUEUE_AW 3	// log2 of the depth

// First fetch address out of reset
`define FETCH_RESET_VECTOR 32'h0000_0000

// PSR privilege pair, kernel when both clear
`define PSR_KERNEL_LO 5
`define PSR_KERNEL_HI 6

// Immediate branch opcode in bits 30 to 21
`define OC_B 10'h0c4

`endif
